/* source/exec_pkg.sv */
// shared widths and queue sizing for the execute stage
// micro-op encoding and the unit tag type

`default_nettype none

package exec_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int data_bits   = 32; // operand and result width
  localparam int reg_bits    = 5;  // destination register address
  localparam int queue_depth = 4;  // max micro-ops in flight
  localparam int count_bits  = 3;  // holds 0 .. queue_depth

  // ------------------------------------------------------------
  // micro-ops
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    uop_add  = 3'd0,
    uop_sub  = 3'd1,
    uop_and  = 3'd2,
    uop_or   = 3'd3,
    uop_xor  = 3'd4,
    uop_sll  = 3'd5,
    uop_mul  = 3'd6, // low 32 bits of product
    uop_mulh = 3'd7  // high 32 bits, signed x signed
  } uop_t;

  // which unit holds an operation
  typedef enum logic {
    unit_alu = 1'b0,
    unit_mul = 1'b1
  } unit_t;

endpackage

`default_nettype wire

/* source/issue_router.sv */
// issue router that classifies a micro-op and picks the unit
// issue is gated on unit readiness and tag queue space

`timescale 1ns/1ps
`default_nettype none

module issue_router import exec_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  issue_val,
  output logic  issue_rdy,
  input  uop_t  issue_uop,
  output logic  alu_in_val,
  input  logic  alu_in_rdy,
  output logic  mul_in_val,
  input  logic  mul_in_rdy,
  output logic  push,
  output unit_t push_tag,
  input  logic  full
);

  unit_t tag;       // target unit of the current micro-op
  logic  unit_rdy;  // target unit can take it

  // multiplies go to the mul unit, everything else to the alu
  always_comb begin
    if ((issue_uop == uop_mul) || (issue_uop == uop_mulh))
      tag = unit_mul;
    else
      tag = unit_alu;
  end

  assign unit_rdy  = (tag == unit_mul) ? mul_in_rdy : alu_in_rdy;
  assign issue_rdy = unit_rdy & ~full; // both the unit and a free queue slot

  // only the chosen unit sees val, and only when the queue has room
  assign alu_in_val = issue_val & ~full & (tag == unit_alu);
  assign mul_in_val = issue_val & ~full & (tag == unit_mul);

  // every issue transfer records its tag in order
  assign push     = issue_val & issue_rdy;
  assign push_tag = tag;

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // decode keeps a stalled micro-op until it is taken
  a_issue_held: assert property (@(posedge clk) disable iff (rst)
    (issue_val && !issue_rdy) |=> (issue_val && (issue_uop == $past(issue_uop))))
    else $error("issue_router: stalled micro-op dropped or changed");

endmodule

`default_nettype wire

/* source/alu_unit.sv */
// alu execute unit holding one input-registered operation
// add, sub, and, or, xor and shift left

`timescale 1ns/1ps
`default_nettype none

module alu_unit import exec_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  uop_t                 uop,
  input  logic [data_bits-1:0] op1,
  input  logic [data_bits-1:0] op2,
  input  logic [reg_bits-1:0]  waddr,
  output logic                 out_val,
  input  logic                 out_rdy,
  output logic [data_bits-1:0] wdata,
  output logic [reg_bits-1:0]  wb_waddr
);

  logic                 val_q;   // holds an operation
  uop_t                 uop_q;
  logic [data_bits-1:0] op1_q;
  logic [data_bits-1:0] op2_q;
  logic [reg_bits-1:0]  waddr_q;

  // ------------------------------------------------------------
  // input register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst)
      val_q <= 1'b0;
    else if (in_val && in_rdy)
      val_q <= 1'b1;
    else if (out_val && out_rdy)
      val_q <= 1'b0; // result left and nothing new came in
  end

  // payload loaded on accept
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      uop_q   <= uop;
      op1_q   <= op1;
      op2_q   <= op2;
      waddr_q <= waddr;
    end
  end

  assign in_rdy = ~val_q | out_rdy; // empty, or draining this cycle

  // ------------------------------------------------------------
  // result
  // ------------------------------------------------------------
  always_comb begin
    case (uop_q)
      uop_add: wdata = op1_q + op2_q;
      uop_sub: wdata = op1_q - op2_q;
      uop_and: wdata = op1_q & op2_q;
      uop_or:  wdata = op1_q | op2_q;
      uop_xor: wdata = op1_q ^ op2_q;
      uop_sll: wdata = op1_q << op2_q[$clog2(data_bits)-1:0]; // low 5 bits
      default: wdata = '0; // multiplies never routed here
    endcase
  end

  assign out_val  = val_q;
  assign wb_waddr = waddr_q;

  // only alu micro-ops are ever held here
  a_uop_alu: assert property (@(posedge clk) disable iff (rst)
    val_q |-> ((uop_q != uop_mul) && (uop_q != uop_mulh)))
    else $error("alu_unit: multiply micro-op held in the alu");

endmodule

`default_nettype wire

/* source/mul_unit.sv */
// multiply execute unit: one input-registered operation
// low product and signed high product from one signed multiply

`timescale 1ns/1ps
`default_nettype none

module mul_unit import exec_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  uop_t                 uop,
  input  logic [data_bits-1:0] op1,
  input  logic [data_bits-1:0] op2,
  input  logic [reg_bits-1:0]  waddr,
  output logic                 out_val,
  input  logic                 out_rdy,
  output logic [data_bits-1:0] wdata,
  output logic [reg_bits-1:0]  wb_waddr
);

  logic                          val_q;
  uop_t                          uop_q;
  logic [data_bits-1:0]          op1_q;
  logic [data_bits-1:0]          op2_q;
  logic [reg_bits-1:0]           waddr_q;
  logic signed [2*data_bits-1:0] prod; // full signed product

  // ------------------------------------------------------------
  // operand register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else begin
      if (in_val && in_rdy)
        val_q <= 1'b1;
      else if (out_val && out_rdy)
        val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin // capture on accept
      uop_q   <= uop;
      op1_q   <= op1;
      op2_q   <= op2;
      waddr_q <= waddr;
    end
  end

  assign in_rdy = ~val_q | out_rdy;

  // ------------------------------------------------------------
  // product
  // ------------------------------------------------------------
  // low half is the same for signed and unsigned operands
  assign prod = $signed(op1_q) * $signed(op2_q);

  always_comb begin
    case (uop_q)
      uop_mulh: wdata = prod[2*data_bits-1:data_bits];
      default:  wdata = prod[data_bits-1:0]; // uop_mul
    endcase
  end

  assign out_val  = val_q; // result the cycle after accept
  assign wb_waddr = waddr_q;

endmodule

`default_nettype wire

/* source/order_queue.sv */
// tag queue: circular buffer of unit tags in issue order
// read/write pointers plus an occupancy counter

`timescale 1ns/1ps
`default_nettype none

module order_queue import exec_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  unit_t push_tag,
  input  logic  pop,
  output unit_t head_tag,
  output logic  empty,
  output logic  full
);

  unit_t                             mem [queue_depth]; // tag storage
  logic [$clog2(queue_depth)-1:0]    wr_ptr;
  logic [$clog2(queue_depth)-1:0]    rd_ptr;
  logic [count_bits-1:0]             count;

  // ------------------------------------------------------------
  // pointers and count
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1; // wraps at queue_depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  // storage has no reset, only written slots are read
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= push_tag;
  end

  assign head_tag = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == count_bits'(queue_depth));

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> !empty)
    else $error("order_queue: pop on empty");

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> !full)
    else $error("order_queue: push on full");

endmodule

`default_nettype wire

/* source/wb_sequencer.sv */
// in-order writeback: head unit onto writeback, out_rdy only to it
// registered hold check for back-pressure stability

`timescale 1ns/1ps
`default_nettype none

module wb_sequencer import exec_pkg::*; (
  input  unit_t                head_tag,
  input  logic                 empty,
  input  logic                 alu_out_val,
  output logic                 alu_out_rdy,
  input  logic [data_bits-1:0] alu_wdata,
  input  logic [reg_bits-1:0]  alu_waddr,
  input  logic                 mul_out_val,
  output logic                 mul_out_rdy,
  input  logic [data_bits-1:0] mul_wdata,
  input  logic [reg_bits-1:0]  mul_waddr,
  output logic                 wb_val,
  input  logic                 wb_rdy,
  output logic [reg_bits-1:0]  wb_waddr,
  output logic [data_bits-1:0] wb_wdata,
  output logic                 pop,
  input  logic                 clk,
  input  logic                 rst
);

  logic                 head_alu; // oldest op sits in the alu
  logic                 hold_q;   // writeback stalled last cycle
  logic [data_bits-1:0] wdata_q;
  logic [reg_bits-1:0]  waddr_q;

  assign head_alu = (head_tag == unit_alu);

  // only the oldest operation may leave
  assign alu_out_rdy = ~empty &  head_alu & wb_rdy;
  assign mul_out_rdy = ~empty & ~head_alu & wb_rdy;

  assign wb_val   = ~empty & (head_alu ? alu_out_val : mul_out_val);
  assign wb_waddr = head_alu ? alu_waddr : mul_waddr;
  assign wb_wdata = head_alu ? alu_wdata : mul_wdata;
  assign pop      = wb_val & wb_rdy; // retire tag on transfer

  // ------------------------------------------------------------
  // stall tracking
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst)
      hold_q <= 1'b0;
    else
      hold_q <= wb_val & ~wb_rdy;
  end

  always_ff @(posedge clk) begin
    wdata_q <= wb_wdata; // snapshot of what was offered
    waddr_q <= wb_waddr;
  end

  // offered writeback stays put until taken
  a_wb_stable: assert property (@(posedge clk) disable iff (rst)
    hold_q |-> (wb_val && (wb_wdata == wdata_q) && (wb_waddr == waddr_q)))
    else $error("wb_sequencer: writeback changed under back-pressure");

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// execute stage top: router, alu and mul units,
// tag queue and in-order writeback sequencer

`timescale 1ns/1ps
`default_nettype none

module execute_stage import exec_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_val,
  output logic                 issue_rdy,
  input  uop_t                 issue_uop,
  input  logic [data_bits-1:0] issue_op1,
  input  logic [data_bits-1:0] issue_op2,
  input  logic [reg_bits-1:0]  issue_waddr,
  output logic                 wb_val,
  input  logic                 wb_rdy,
  output logic [reg_bits-1:0]  wb_waddr,
  output logic [data_bits-1:0] wb_wdata
);

  // ------------------------------------------------------------
  // internal wires
  // ------------------------------------------------------------
  logic                 alu_in_val, alu_in_rdy, mul_in_val, mul_in_rdy;
  logic                 alu_out_val, alu_out_rdy, mul_out_val, mul_out_rdy;
  logic [data_bits-1:0] alu_wdata, mul_wdata;
  logic [reg_bits-1:0]  alu_waddr, mul_waddr;
  logic                 push, pop, empty, full;
  unit_t                push_tag, head_tag;

  issue_router u_router (
    .clk, .rst, .issue_val, .issue_rdy, .issue_uop,
    .alu_in_val, .alu_in_rdy, .mul_in_val, .mul_in_rdy,
    .push, .push_tag, .full
  );

  // operands fan out to both units, val picks one
  alu_unit u_alu (
    .clk, .rst, .in_val(alu_in_val), .in_rdy(alu_in_rdy),
    .uop(issue_uop), .op1(issue_op1), .op2(issue_op2), .waddr(issue_waddr),
    .out_val(alu_out_val), .out_rdy(alu_out_rdy),
    .wdata(alu_wdata), .wb_waddr(alu_waddr)
  );

  mul_unit u_mul (
    .clk, .rst, .in_val(mul_in_val), .in_rdy(mul_in_rdy),
    .uop(issue_uop), .op1(issue_op1), .op2(issue_op2), .waddr(issue_waddr),
    .out_val(mul_out_val), .out_rdy(mul_out_rdy),
    .wdata(mul_wdata), .wb_waddr(mul_waddr)
  );

  order_queue u_queue (
    .clk, .rst, .push, .push_tag, .pop, .head_tag, .empty, .full
  );

  wb_sequencer u_seq (
    .head_tag, .empty,
    .alu_out_val, .alu_out_rdy, .alu_wdata, .alu_waddr,
    .mul_out_val, .mul_out_rdy, .mul_wdata, .mul_waddr,
    .wb_val, .wb_rdy, .wb_waddr, .wb_wdata, .pop, .clk, .rst
  );

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
// testbench clock, 4 ns period
// synchronous reset held high for the first 4 rising edges

`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0; // released with the other inputs, 1 ns after the edge
  end

endmodule

`default_nettype wire

/* sim/tb_execute_stage.sv */
// testbench for the execute stage with directed latency, mulh corner
// and back-pressure phases, then a random issue stream
// reference model queue, value checks and a cycle timeout

`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage import exec_pkg::*; ();

  localparam int total_issues   = 2000;
  localparam int timeout_cycles = total_issues * 4 + 100;
  localparam int latency_issues = 24;
  localparam int burst_tries    = 12;
  localparam int random_issues  = 1900; // rest of the budget after directed phases

  logic                 clk;
  logic                 rst;
  logic                 issue_val;
  logic                 issue_rdy;
  uop_t                 issue_uop;
  logic [data_bits-1:0] issue_op1;
  logic [data_bits-1:0] issue_op2;
  logic [reg_bits-1:0]  issue_waddr;
  logic                 wb_val;
  logic                 wb_rdy;
  logic [reg_bits-1:0]  wb_waddr;
  logic [data_bits-1:0] wb_wdata;

  logic [data_bits-1:0] exp_data [$]; // model queue with the oldest entry first
  logic [reg_bits-1:0]  exp_addr [$];
  int                   exp_cycle [$]; // cycle of the issue transfer
  int                   cycle_count = 0;
  int                   issue_count = 0;
  int                   wb_count    = 0;
  int                   issue_cycle;
  int                   wb_mode; // 0 ready, 1 stalled, 2 random with bursts
  logic                 check_latency;

  // mulh corner operands with sign and extreme values
  logic [31:0] edge_a [6] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff,
                              32'h8000_0000, 32'hffff_ffff, 32'h1234_5678};
  logic [31:0] edge_b [6] = '{32'h8000_0000, 32'h7fff_ffff, 32'h0000_0002,
                              32'h7fff_ffff, 32'hffff_ffff, 32'hfedc_ba98};

  clock_gen clkgen (.clk, .rst);

  execute_stage uut (
    .clk, .rst, .issue_val, .issue_rdy, .issue_uop, .issue_op1, .issue_op2,
    .issue_waddr, .wb_val, .wb_rdy, .wb_waddr, .wb_wdata
  );

  // ------------------------------------------------------------
  // model and check helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] expected_result(uop_t u, logic [31:0] a, logic [31:0] b);
    logic [63:0] wide;
    wide = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // sign extended so low 64 bits are signed
    case (u)
      uop_add: return a + b;
      uop_sub: return a - b;
      uop_and: return a & b;
      uop_or:  return a | b;
      uop_xor: return a ^ b;
      uop_sll: return a << b[4:0];
      uop_mul: return wide[31:0];
      default: return wide[63:32]; // mulh
    endcase
  endfunction

  task automatic stop_on_error();
    $display("Test FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // ------------------------------------------------------------
  // stimulus helpers entered and left 1 ns after an edge
  // ------------------------------------------------------------
  task automatic issue_op(input uop_t u, input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] wa);
    issue_val   = 1'b1;
    issue_uop   = u;
    issue_op1   = a;
    issue_op2   = b;
    issue_waddr = wa;
    #2;
    while (!issue_rdy) begin // hold until the stage takes it
      @(posedge clk);
      #3;
    end
    @(posedge clk); // transfer edge
    #1;
  endtask

  task automatic issue_random();
    issue_op(uop_t'($urandom_range(0, 7)), $urandom, $urandom, 5'($urandom));
  endtask

  task automatic idle_cycles(input int n);
    issue_val = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drain_results();
    issue_val = 1'b0;
    while (exp_data.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ------------------------------------------------------------
  // timeout, writeback ready, monitor
  // ------------------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: no end of run within %0d cycles", timeout_cycles);
      stop_on_error();
    end
  end

  initial begin : wb_ready_driver
    int burst_left;
    int mode;
    burst_left = 0;
    wb_rdy     = 1'b1;
    forever begin
      @(posedge clk);
      mode = wb_mode; // mode taken at the edge
      #1;
      case (mode)
        0: wb_rdy = 1'b1;
        1: wb_rdy = 1'b0;
        default: begin
          if (burst_left > 0) begin // long stall in progress
            burst_left--;
            wb_rdy = 1'b0;
          end else if ($urandom_range(0, 63) == 0) begin
            burst_left = $urandom_range(8, 20);
            wb_rdy     = 1'b0;
          end else begin
            wb_rdy = ($urandom_range(0, 3) != 0); // 75% ready
          end
        end
      endcase
    end
  end

  // sampled 3 ns in once inputs and comb paths settle
  always @(posedge clk) begin
    #3;
    if (!rst) begin
      if (wb_val && wb_rdy) begin
        if (exp_data.size() == 0) begin
          $display("writeback to x%0d with no micro-op outstanding", wb_waddr);
          stop_on_error();
        end else begin
          issue_cycle = exp_cycle.pop_front();
          check_value("wb_wdata", wb_wdata, exp_data.pop_front());
          check_value("wb_waddr", 32'(wb_waddr), 32'(exp_addr.pop_front()));
          if (check_latency)
            check_value("wb latency", cycle_count - issue_cycle, 32'd1);
          wb_count++;
        end
      end
      if (check_latency && issue_val && !issue_rdy) begin
        $display("issue stalled while writeback stayed ready");
        stop_on_error();
      end
      if (issue_val && issue_rdy) begin
        exp_data.push_back(expected_result(issue_uop, issue_op1, issue_op2));
        exp_addr.push_back(issue_waddr);
        exp_cycle.push_back(cycle_count);
        issue_count++;
      end
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    int   accepts;
    logic held;
    logic saw_stall;
    void'($urandom(40));
    issue_val     = 1'b0;
    issue_uop     = uop_add;
    issue_op1     = '0;
    issue_op2     = '0;
    issue_waddr   = '0;
    wb_mode       = 0;
    check_latency = 1'b0;

    wait (rst == 1'b0);
    #2;
    check_value("wb_val", 32'(wb_val), 32'd0); // idle after reset
    check_value("issue_rdy", 32'(issue_rdy), 32'd1);
    @(posedge clk);
    #1;

    // back-to-back stream with one result per cycle at latency one
    check_latency = 1'b1;
    repeat (latency_issues) issue_random();
    for (int i = 0; i < 6; i++) begin
      issue_op(uop_mul, edge_a[i], edge_b[i], 5'(2 * i));
      issue_op(uop_mulh, edge_a[i], edge_b[i], 5'(2 * i + 1));
    end
    drain_results();
    check_latency = 1'b0;

    // writeback held off so the stage fills and closes issue
    wb_mode = 1;
    idle_cycles(2);
    accepts   = 0;
    held      = 1'b0;
    saw_stall = 1'b0;
    for (int i = 0; i < burst_tries; i++) begin
      issue_val = 1'b1;
      if (!held) begin
        issue_uop   = uop_t'($urandom_range(0, 7));
        issue_op1   = $urandom;
        issue_op2   = $urandom;
        issue_waddr = 5'($urandom);
      end
      #2;
      held = ~issue_rdy;
      if (issue_rdy)
        accepts++;
      else
        saw_stall = 1'b1;
      @(posedge clk);
      #1;
    end
    if (accepts > queue_depth || !saw_stall || wb_count != issue_count - accepts) begin
      $display("stall phase: %0d accepted, issue_rdy low seen %0b", accepts, saw_stall);
      stop_on_error();
    end
    wb_mode = 0;
    if (held) begin
      #2;
      while (!issue_rdy) begin // pending op goes in once writeback opens
        @(posedge clk);
        #3;
      end
      @(posedge clk);
      #1;
    end
    drain_results();

    // random mixed stream under random back-pressure
    wb_mode = 2;
    for (int n = 0; n < random_issues; ) begin
      if ($urandom_range(0, 3) != 0) begin
        issue_random();
        n++;
      end else begin
        idle_cycles(1);
      end
    end
    wb_mode = 0;
    drain_results();
    idle_cycles(2);

    check_value("model queue size", exp_data.size(), 32'd0);
    check_value("writeback count", wb_count, issue_count);
    check_value("wb_val", 32'(wb_val), 32'd0);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
source/exec_pkg.sv
source/issue_router.sv
source/alu_unit.sv
source/mul_unit.sv
source/order_queue.sv
source/wb_sequencer.sv
source/execute_stage.sv
sim/clock_gen.sv
sim/tb_execute_stage.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator, judge by the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_execute_stage -f files.f \
  -o sim_exec > sim.log 2>&1 || { cat sim.log; echo "build failed"; exit 1; }
./obj_dir/sim_exec >> sim.log 2>&1 || echo "simulator returned an error status"
grep -q "Test FAILED" sim.log && { cat sim.log; echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { cat sim.log; echo "run ended without a result"; exit 1; }
echo "simulation passed"
